//--- tests/stim_transactions.txt
# name  token_pid(hex)  ep  rdy  par  seq  mode  exp_pid(hex, 0 = none)  exp_finish  exp_mux
# mode 0 normal, 1 unconfigured, 2 endpoint halted, 3 no data packet
ping_ack     4 1 1 0 0 0 2 1 1
ping_nak     4 1 0 0 0 0 a 1 1
ping_stall   4 5 1 0 0 0 e 0 7
ping_ep0     4 0 1 0 0 0 2 0 0
out_seq0     1 1 1 0 0 0 2 1 1
out_seq1     1 1 1 1 1 0 2 1 1
out_bad_seq  1 1 1 0 1 0 0 0 1
in_data0     9 2 1 0 0 0 3 1 2
in_data1     9 2 1 1 0 0 b 1 2
out_timeout  1 1 1 0 0 3 0 0 1
ping_unconf  4 1 1 0 0 1 e 0 1
ping_reconf  4 1 1 0 0 0 2 1 1
ping_halted  4 1 1 0 0 2 e 0 1
ping_after   4 1 1 0 0 0 2 1 1

//--- src.f
source/usb_pkg.sv
source/proto_pkg.sv
source/ep_control.sv
source/proto_fsm.sv
source/bus_timers.sv
source/response_regs.sv
source/usb_protocol.sv
tests/usb_protocol_chk.sv
tests/tb_usb_protocol.sv

//--- Bender.yml
package:
  name: usb_protocol

sources:
  - source/usb_pkg.sv
  - source/proto_pkg.sv
  - source/ep_control.sv
  - source/proto_fsm.sv
  - source/bus_timers.sv
  - source/response_regs.sv
  - source/usb_protocol.sv
  - target: test
    files:
      - tests/usb_protocol_chk.sv
      - tests/tb_usb_protocol.sv

//--- tests/tb_usb_protocol.sv
`timescale 1ns/1ps

module tb_usb_protocol
  import usb_pkg::*, proto_pkg::*;
();

  localparam logic [3:0] OUT_EP   = 4'd1;
  localparam logic [3:0] IN_EP    = 4'd2;
  localparam int         TD_LIMIT = 23;
  localparam logic [6:0] DEV_ADDR = 7'h2a;

  logic       clock;
  logic       reset;
  logic       set_conf_i;
  logic       clr_conf_i;
  logic [6:0] usb_addr_i;
  token_t     token_i;
  logic       tok_recv_i;
  usb_pid_u   data_pid_i;
  logic       rx_start_i;
  logic       usb_recv_i;
  logic       crc_error_i;
  logic       eop_recv_i;
  logic       usb_busy_i;
  logic       usb_sent_i;
  logic       hsk_sent_i;
  logic       hsk_recv_i;
  logic       ep0_select_i;
  logic       ep0_parity_i;
  ep_status_t ep_out_i;
  ep_status_t ep_in_i;
  logic       timedout_o;
  logic       hsk_send_o;
  logic       mux_enable_o;
  logic [2:0] mux_select_o;
  logic [3:0] ulpi_tuser_o;
  logic       ep_out_select_o;
  logic       ep_in_select_o;
  logic       ep_out_finish_o;
  logic       ep_in_finish_o;

  string test_name;

  usb_protocol #(
    .BULK_OUT_EP(OUT_EP),
    .BULK_IN_EP (IN_EP),
    .TA_LIMIT   (101),
    .EP_LIMIT   (23),
    .TD_LIMIT   (TD_LIMIT)
  ) i_usb_protocol (.*);

  always #20 clock = ~clock;

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic watched(input int which);
    case (which)
      0:       return hsk_send_o;
      1:       return mux_enable_o;
      default: return timedout_o;
    endcase
  endfunction

  task automatic wait_for(input int which, input string what, input int limit);
    int cycles;
    cycles = 0;
    while (watched(which) !== 1'b1) begin
      if (cycles >= limit) begin
        $display("Test %s waited %0d cycles for %s, which never came", test_name, limit, what);
        abort_run();
      end
      next_cycle();
      cycles++;
    end
  endtask

  // Drop the configuration, then set it again when asked
  task automatic configure(input logic enable);
    clr_conf_i = 1'b1;
    next_cycle();
    clr_conf_i = 1'b0;
    set_conf_i = enable;
    next_cycle();
    set_conf_i = 1'b0;
    next_cycle();
  endtask

  task automatic run_test(input logic [3:0] op, input logic [3:0] ep, input logic rdy,
                          input logic par, input logic seq, input int mode,
                          input logic [3:0] exp_pid, input logic exp_fin,
                          input logic [2:0] exp_mux);
    logic out_sel_exp;
    logic in_sel_exp;
    // A bulk endpoint is selected only while configured and not halted
    out_sel_exp = ep == OUT_EP && mode != 1 && mode != 2;
    in_sel_exp  = ep == IN_EP && mode != 1 && mode != 2;
    // Status order is rx_rdy, tx_rdy, parity, halted
    ep_out_i = {rdy, 1'b0, par, mode == 2};
    ep_in_i  = {1'b0, rdy, par, mode == 2};
    configure(mode != 1);
    token_i.pid.code = usb_pid_e'(op);
    token_i.addr     = DEV_ADDR;
    token_i.endp     = ep;
    tok_recv_i       = 1'b1;
    next_cycle();
    tok_recv_i = 1'b0;
    check_value("out select", out_sel_exp, ep_out_select_o);
    check_value("in select", in_sel_exp, ep_in_select_o);
    if (op == PID_IN) begin
      wait_for(1, "mux enable", 8);
      check_value("data pid", exp_pid, ulpi_tuser_o);
      check_value("mux select", exp_mux, mux_select_o);
      usb_busy_i = 1'b1;
      next_cycle();
      usb_busy_i = 1'b0;
      usb_sent_i = 1'b1;
      next_cycle();
      usb_sent_i = 1'b0;
      hsk_recv_i = 1'b1;
      next_cycle();
      hsk_recv_i = 1'b0;
      check_value("in finish", exp_fin, ep_in_finish_o);
    end else if (mode == 3) begin
      // No data packet, so the token-to-data timer has to fire
      wait_for(2, "timeout", TD_LIMIT + 3);
      check_value("mux select", exp_mux, mux_select_o);
    end else begin
      if (op != PID_PING) begin
        rx_start_i = 1'b1;
        next_cycle();
        rx_start_i      = 1'b0;
        usb_recv_i      = 1'b1;
        data_pid_i.code = seq ? PID_DATA1 : PID_DATA0;
        next_cycle();
        usb_recv_i = 1'b0;
      end
      if (exp_pid == 4'h0) begin
        check_value("mux select", exp_mux, mux_select_o);
        repeat (4) begin
          check_value("handshake request", 8'h0, hsk_send_o);
          next_cycle();
        end
      end else begin
        wait_for(0, "handshake request", 8);
        check_value("handshake pid", exp_pid, ulpi_tuser_o);
        check_value("mux select", exp_mux, mux_select_o);
        usb_busy_i = 1'b1;
        next_cycle();
        usb_busy_i = 1'b0;
        hsk_sent_i = 1'b1;
        next_cycle();
        hsk_sent_i = 1'b0;
        check_value("handshake request", 8'h0, hsk_send_o);
        check_value("out finish", exp_fin, ep_out_finish_o);
      end
    end
    ep_out_i = '0;
    ep_in_i  = '0;
    repeat (3) next_cycle();
  endtask

  initial begin
    int    fd;
    int    fields;
    int    count;
    int    op, ep, rdy, par, seq, mode, exp_pid, exp_fin, exp_mux;
    string line;
    clock        = 1'b0;
    reset        = 1'b1;
    set_conf_i   = 1'b0;
    clr_conf_i   = 1'b0;
    usb_addr_i   = DEV_ADDR;
    token_i      = '0;
    tok_recv_i   = 1'b0;
    data_pid_i   = '0;
    rx_start_i   = 1'b0;
    usb_recv_i   = 1'b0;
    crc_error_i  = 1'b0;
    eop_recv_i   = 1'b0;
    usb_busy_i   = 1'b0;
    usb_sent_i   = 1'b0;
    hsk_sent_i   = 1'b0;
    hsk_recv_i   = 1'b0;
    ep0_select_i = 1'b0;
    ep0_parity_i = 1'b0;
    ep_out_i     = '0;
    ep_in_i      = '0;
    count        = 0;
    repeat (8) @(posedge clock);
    #2;
    reset     = 1'b0;
    test_name = "reset";
    check_value("handshake request", 8'h0, hsk_send_o);
    check_value("mux enable", 8'h0, mux_enable_o);
    check_value("timeout", 8'h0, timedout_o);
    check_value("out select", 8'h0, ep_out_select_o);
    check_value("in select", 8'h0, ep_in_select_o);
    check_value("out finish", 8'h0, ep_out_finish_o);
    check_value("in finish", 8'h0, ep_in_finish_o);
    fd = $fopen("tests/stim_transactions.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tests/stim_transactions.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line   = "";
      fields = $fgets(line, fd);
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        fields = $sscanf(line, "%s %h %d %d %d %d %d %h %d %d", test_name, op, ep, rdy,
                         par, seq, mode, exp_pid, exp_fin, exp_mux);
        if (fields != 10) begin
          $display("Malformed line in the stimulus file: %s", line);
          abort_run();
        end
        run_test(op, ep, rdy, par, seq, mode, exp_pid, exp_fin, exp_mux);
        count++;
      end
    end
    $fclose(fd);
    if (count == 0) begin
      $display("The stimulus file holds no transactions");
    end
    if (count > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- tests/usb_protocol_chk.sv
`timescale 1ns/1ps

module usb_protocol_chk
  import proto_pkg::*;
(
  input logic         clock,
  input logic         reset,
  input proto_state_e state_i,
  input logic         hsk_send_i,
  input logic         timedout_i,
  input logic         ep_out_select_i,
  input logic         ep_in_select_i
);

  // No handshake may compete with an outgoing data packet
  a_no_hsk_in_send: assert property (@(posedge clock) disable iff (reset)
    state_i == ST_SEND |-> !hsk_send_i)
    else $error("Handshake request raised while the FSM sends data");

  a_timeout_pulse: assert property (@(posedge clock) disable iff (reset)
    timedout_i |=> !timedout_i)
    else $error("Timeout held for more than one cycle");

  a_one_select: assert property (@(posedge clock) disable iff (reset)
    !(ep_out_select_i && ep_in_select_i))
    else $error("Both bulk endpoints selected at once");

endmodule

bind usb_protocol usb_protocol_chk i_usb_protocol_chk (
  .clock          (clock),
  .reset          (reset),
  .state_i        (state_w),
  .hsk_send_i     (hsk_send_o),
  .timedout_i     (timedout_o),
  .ep_out_select_i(ep_out_select_o),
  .ep_in_select_i (ep_in_select_o)
);

//--- source/usb_protocol.sv
`timescale 1ns/1ps

module usb_protocol
  import usb_pkg::*, proto_pkg::*;
#(
  parameter logic [3:0] BULK_OUT_EP = 4'd1,
  parameter logic [3:0] BULK_IN_EP  = 4'd2,
  parameter int         TA_LIMIT    = TA_LIMIT_DEFAULT,
  parameter int         EP_LIMIT    = EP_LIMIT_DEFAULT,
  parameter int         TD_LIMIT    = TD_LIMIT_DEFAULT
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  logic [6:0] usb_addr_i,
  input  token_t     token_i,
  input  logic       tok_recv_i,
  input  usb_pid_u   data_pid_i,
  input  logic       rx_start_i,
  input  logic       usb_recv_i,
  input  logic       crc_error_i,
  input  logic       eop_recv_i,
  input  logic       usb_busy_i,
  input  logic       usb_sent_i,
  input  logic       hsk_sent_i,
  input  logic       hsk_recv_i,
  input  logic       ep0_select_i,
  input  logic       ep0_parity_i,
  input  ep_status_t ep_out_i,
  input  ep_status_t ep_in_i,
  output logic       timedout_o,
  output logic       hsk_send_o,
  output logic       mux_enable_o,
  output logic [2:0] mux_select_o,
  output logic [3:0] ulpi_tuser_o,
  output logic       ep_out_select_o,
  output logic       ep_in_select_o,
  output logic       ep_out_finish_o,
  output logic       ep_in_finish_o
);

  ep_route_t    route_w;
  proto_state_e state_w;
  usb_pid_e     pid_w;
  timer_start_t start_w;

  ep_control #(
    .BULK_OUT_EP(BULK_OUT_EP),
    .BULK_IN_EP (BULK_IN_EP)
  ) i_ep_control (
    .clock          (clock),
    .reset          (reset),
    .set_conf_i     (set_conf_i),
    .clr_conf_i     (clr_conf_i),
    .usb_addr_i     (usb_addr_i),
    .token_i        (token_i),
    .tok_recv_i     (tok_recv_i),
    .data_pid_i     (data_pid_i),
    .hsk_recv_i     (hsk_recv_i),
    .hsk_sent_i     (hsk_sent_i),
    .timeout_i      (timedout_o),
    .ep0_select_i   (ep0_select_i),
    .ep0_parity_i   (ep0_parity_i),
    .ep_out_i       (ep_out_i),
    .ep_in_i        (ep_in_i),
    .route_o        (route_w),
    .ep_out_select_o(ep_out_select_o),
    .ep_in_select_o (ep_in_select_o),
    .ep_out_finish_o(ep_out_finish_o),
    .ep_in_finish_o (ep_in_finish_o)
  );

  proto_fsm i_proto_fsm (
    .clock      (clock),
    .reset      (reset),
    .token_i    (token_i),
    .tok_recv_i (tok_recv_i),
    .usb_recv_i (usb_recv_i),
    .crc_error_i(crc_error_i),
    .eop_recv_i (eop_recv_i),
    .usb_sent_i (usb_sent_i),
    .hsk_sent_i (hsk_sent_i),
    .hsk_recv_i (hsk_recv_i),
    .route_i    (route_w),
    .timeout_i  (timedout_o),
    .state_o    (state_w),
    .pid_o      (pid_w),
    .start_o    (start_w)
  );

  bus_timers #(
    .TA_LIMIT(TA_LIMIT),
    .EP_LIMIT(EP_LIMIT),
    .TD_LIMIT(TD_LIMIT)
  ) i_bus_timers (
    .clock     (clock),
    .reset     (reset),
    .start_i   (start_w),
    .rx_start_i(rx_start_i),
    .usb_busy_i(usb_busy_i),
    .hsk_recv_i(hsk_recv_i),
    .timeout_o (timedout_o)
  );

  response_regs #(
    .BULK_OUT_EP(BULK_OUT_EP),
    .BULK_IN_EP (BULK_IN_EP)
  ) i_response_regs (
    .clock       (clock),
    .reset       (reset),
    .state_i     (state_w),
    .pid_i       (pid_w),
    .token_i     (token_i),
    .tok_recv_i  (tok_recv_i),
    .usb_recv_i  (usb_recv_i),
    .hsk_sent_i  (hsk_sent_i),
    .route_i     (route_w),
    .hsk_send_o  (hsk_send_o),
    .mux_enable_o(mux_enable_o),
    .mux_select_o(mux_select_o),
    .ulpi_tuser_o(ulpi_tuser_o)
  );

endmodule

//--- source/response_regs.sv
`timescale 1ns/1ps

module response_regs
  import usb_pkg::*, proto_pkg::*;
#(
  parameter logic [3:0] BULK_OUT_EP = 4'd1,
  parameter logic [3:0] BULK_IN_EP  = 4'd2
) (
  input  logic         clock,
  input  logic         reset,
  input  proto_state_e state_i,
  input  usb_pid_e     pid_i,
  input  token_t       token_i,
  input  logic         tok_recv_i,
  input  logic         usb_recv_i,
  input  logic         hsk_sent_i,
  input  ep_route_t    route_i,
  output logic         hsk_send_o,
  output logic         mux_enable_o,
  output logic [2:0]   mux_select_o,
  output logic [3:0]   ulpi_tuser_o
);

  logic ping_w;

  assign ping_w = tok_recv_i && route_i.tok_match && token_i.pid.code == PID_PING;

  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_o   <= 1'b0;
      mux_enable_o <= 1'b0;
      mux_select_o <= 3'd0;
    end else begin
      mux_enable_o <= state_i inside {ST_SEND, ST_WAIT};
      case (token_i.endp)
        4'd0:        mux_select_o <= 3'd0;
        BULK_OUT_EP: mux_select_o <= 3'd1;
        BULK_IN_EP:  mux_select_o <= 3'd2;
        default:     mux_select_o <= 3'd7;
      endcase
      // Handshake goes out after a PING or a good DATAx
      case (state_i)
        ST_IDLE: hsk_send_o <= ping_w;
        ST_RECV: if (usb_recv_i && route_i.par_ok) hsk_send_o <= 1'b1;
        ST_RESP: if (hsk_sent_i) hsk_send_o <= 1'b0;
        default: hsk_send_o <= 1'b0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    ulpi_tuser_o <= pid_i;
  end

endmodule

//--- source/bus_timers.sv
`timescale 1ns/1ps

module bus_timers
  import proto_pkg::*;
#(
  parameter int TA_LIMIT = TA_LIMIT_DEFAULT,
  parameter int EP_LIMIT = EP_LIMIT_DEFAULT,
  parameter int TD_LIMIT = TD_LIMIT_DEFAULT
) (
  input  logic         clock,
  input  logic         reset,
  input  timer_start_t start_i,
  input  logic         rx_start_i,
  input  logic         usb_busy_i,
  input  logic         hsk_recv_i,
  output logic         timeout_o
);

  localparam int MAX_LIMIT = (TA_LIMIT > EP_LIMIT)
                           ? ((TA_LIMIT > TD_LIMIT) ? TA_LIMIT : TD_LIMIT)
                           : ((EP_LIMIT > TD_LIMIT) ? EP_LIMIT : TD_LIMIT);
  // Extra top bit flags the wrap below zero
  localparam int CW = $clog2(MAX_LIMIT) + 1;

  logic [2:0] start_w;
  logic [2:0] event_w;
  logic [2:0] err_w;
  logic       timeout_q;

  // Index 2 is token-to-data, 1 endpoint response, 0 turnaround
  assign start_w = start_i;
  assign event_w = {rx_start_i, usb_busy_i, hsk_recv_i};

  for (genvar i = 0; i < 3; i++) begin : g_timer
    localparam int LIMIT = (i == 2) ? TD_LIMIT : (i == 1) ? EP_LIMIT : TA_LIMIT;
    localparam logic [CW-1:0] LOAD = CW'(LIMIT - 1);

    logic          run_q;
    logic          err_q;
    logic [CW-1:0] count_q;
    logic [CW-1:0] count_dec_w;

    assign count_dec_w = count_q - CW'(1);
    assign err_w[i]    = err_q;

    always_ff @(posedge clock) begin
      if (reset) begin
        run_q <= 1'b0;
        err_q <= 1'b0;
      end else if (start_w[i]) begin
        run_q <= 1'b1;
        err_q <= 1'b0;
      end else if (run_q && (event_w[i] || count_dec_w[CW-1])) begin
        // Expired unless the awaited event got here first
        run_q <= 1'b0;
        err_q <= !event_w[i];
      end else begin
        err_q <= 1'b0;
      end
    end

    always_ff @(posedge clock) begin
      if (start_w[i]) begin
        count_q <= LOAD;
      end else if (run_q) begin
        count_q <= count_dec_w;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= |err_w;
    end
  end

  assign timeout_o = timeout_q;

endmodule

//--- source/proto_fsm.sv
`timescale 1ns/1ps

module proto_fsm
  import usb_pkg::*, proto_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  token_t       token_i,
  input  logic         tok_recv_i,
  input  logic         usb_recv_i,
  input  logic         crc_error_i,
  input  logic         eop_recv_i,
  input  logic         usb_sent_i,
  input  logic         hsk_sent_i,
  input  logic         hsk_recv_i,
  input  ep_route_t    route_i,
  input  logic         timeout_i,
  output proto_state_e state_o,
  output usb_pid_e     pid_o,
  output timer_start_t start_o
);

  proto_state_e state_q;
  proto_state_e state_d;
  usb_pid_e     pid_q;
  usb_pid_e     pid_d;

  always_comb begin
    state_d = state_q;
    pid_d   = pid_q;
    case (state_q)
      ST_IDLE: begin
        if (tok_recv_i && route_i.tok_match) begin
          case (token_i.pid.code)
            PID_SETUP: begin
              if (route_i.ep0) begin
                state_d = ST_RECV;
              end else begin
                state_d = ST_DROP;
                pid_d   = PID_STALL;
              end
            end
            PID_OUT: begin
              if (route_i.ep0 || route_i.out_rdy) begin
                state_d = ST_RECV;
              end else begin
                // Selected but full gets NAK, anything else STALL
                state_d = ST_DROP;
                pid_d   = route_i.out_sel ? PID_NAK : PID_STALL;
              end
            end
            PID_IN: begin
              pid_d = route_i.seq ? PID_DATA1 : PID_DATA0;
              if (route_i.ep0 || route_i.in_rdy) begin
                state_d = ST_SEND;
              end else if (route_i.in_sel) begin
                state_d = ST_RESP;
                pid_d   = PID_NAK;
              end else begin
                // Unsupported, let the host time out
                state_d = ST_WAIT;
              end
            end
            PID_PING: begin
              state_d = ST_RESP;
              if (route_i.ep0 || route_i.out_rdy) begin
                pid_d = PID_ACK;
              end else begin
                pid_d = route_i.out_sel ? PID_NAK : PID_STALL;
              end
            end
            default: begin
              state_d = ST_IDLE;
            end
          endcase
        end
      end
      ST_RECV: begin
        if (usb_recv_i) begin
          // Sequence error drops the packet silently
          state_d = route_i.par_ok ? ST_RESP : ST_IDLE;
          pid_d   = PID_ACK;
        end else if (timeout_i || crc_error_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_RESP: if (hsk_sent_i || timeout_i) state_d = ST_IDLE;
      ST_SEND: begin
        if (usb_sent_i) begin
          state_d = ST_WAIT;
        end else if (timeout_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_WAIT: if (hsk_recv_i || timeout_i) state_d = ST_IDLE;
      ST_DROP: if (eop_recv_i || timeout_i) state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clock) begin
    pid_q <= pid_d;
  end

  // Timers start as the FSM begins to wait on the bus
  always_comb begin
    start_o.td = state_q == ST_IDLE && state_d == ST_RECV;
    start_o.ep = (state_q == ST_IDLE || state_q == ST_RECV)
              && state_d inside {ST_SEND, ST_RESP, ST_WAIT};
    start_o.ta = state_q == ST_SEND && state_d == ST_WAIT;
  end

  assign state_o = state_q;
  assign pid_o   = pid_d;

endmodule

//--- source/ep_control.sv
`timescale 1ns/1ps

module ep_control
  import usb_pkg::*, proto_pkg::*;
#(
  parameter logic [3:0] BULK_OUT_EP = 4'd1,
  parameter logic [3:0] BULK_IN_EP  = 4'd2
) (
  input  logic       clock,
  input  logic       reset,
  input  logic       set_conf_i,
  input  logic       clr_conf_i,
  input  logic [6:0] usb_addr_i,
  input  token_t     token_i,
  input  logic       tok_recv_i,
  input  usb_pid_u   data_pid_i,
  input  logic       hsk_recv_i,
  input  logic       hsk_sent_i,
  input  logic       timeout_i,
  input  logic       ep0_select_i,
  input  logic       ep0_parity_i,
  input  ep_status_t ep_out_i,
  input  ep_status_t ep_in_i,
  output ep_route_t  route_o,
  output logic       ep_out_select_o,
  output logic       ep_in_select_o,
  output logic       ep_out_finish_o,
  output logic       ep_in_finish_o
);

  logic out_en_q;
  logic in_en_q;
  logic end_q;
  logic tok_match_w;
  logic ep0_w;
  logic out_hit_w;
  logic in_hit_w;
  logic data_seq_w;

  assign tok_match_w = token_i.addr == usb_addr_i;
  assign ep0_w       = token_i.endp == 4'd0;
  assign out_hit_w   = out_en_q && token_i.endp == BULK_OUT_EP;
  assign in_hit_w    = in_en_q && token_i.endp == BULK_IN_EP;
  assign data_seq_w  = data_pid_i.bits.seq;

  // A halt drops the enable until the host configures again
  always_ff @(posedge clock) begin
    if (reset || clr_conf_i || ep_out_i.halted) begin
      out_en_q <= 1'b0;
    end else if (set_conf_i) begin
      out_en_q <= 1'b1;
    end
    if (reset || clr_conf_i || ep_in_i.halted) begin
      in_en_q <= 1'b0;
    end else if (set_conf_i) begin
      in_en_q <= 1'b1;
    end
  end

  // Transaction over, drop selects on the next edge
  always_ff @(posedge clock) begin
    end_q <= reset || clr_conf_i || hsk_recv_i || hsk_sent_i || timeout_i;
  end

  always_ff @(posedge clock) begin
    if (reset || end_q) begin
      ep_out_select_o <= 1'b0;
      ep_in_select_o  <= 1'b0;
      ep_out_finish_o <= 1'b0;
      ep_in_finish_o  <= 1'b0;
    end else begin
      if (tok_recv_i && tok_match_w) begin
        ep_out_select_o <= out_hit_w;
        ep_in_select_o  <= in_hit_w;
      end
      // OUT completes when our ACK leaves, IN when the host ACKs
      ep_out_finish_o <= ep_out_select_o && hsk_sent_i;
      ep_in_finish_o  <= ep_in_select_o && hsk_recv_i;
    end
  end

  always_comb begin
    route_o.tok_match = tok_match_w;
    route_o.ep0       = ep0_w;
    route_o.out_sel   = out_hit_w;
    route_o.out_rdy   = out_hit_w && !ep_out_i.halted && ep_out_i.rx_rdy;
    route_o.in_sel    = in_hit_w;
    route_o.in_rdy    = in_hit_w && !ep_in_i.halted && ep_in_i.tx_rdy;
    route_o.par_ok    = (ep0_select_i && ep0_parity_i == data_seq_w)
                     || (out_hit_w && ep_out_i.parity == data_seq_w);
    // Toggle to use for the next DATAx we send
    if (ep0_w) begin
      route_o.seq = ep0_parity_i;
    end else if (token_i.endp == BULK_IN_EP) begin
      route_o.seq = ep_in_i.parity;
    end else if (token_i.endp == BULK_OUT_EP) begin
      route_o.seq = ep_out_i.parity;
    end else begin
      route_o.seq = 1'b0;
    end
  end

endmodule

//--- source/proto_pkg.sv
package proto_pkg;

  // One-hot transaction states
  typedef enum logic [5:0] {
    ST_IDLE = 6'b000001,
    ST_RECV = 6'b000010,
    ST_RESP = 6'b000100,
    ST_DROP = 6'b001000,
    ST_SEND = 6'b010000,
    ST_WAIT = 6'b100000
  } proto_state_e;

  typedef struct packed {
    logic rx_rdy;
    logic tx_rdy;
    logic parity;
    logic halted;
  } ep_status_t;

  typedef struct packed {
    logic tok_match;
    logic ep0;
    logic out_sel;
    logic out_rdy;
    logic in_sel;
    logic in_rdy;
    logic par_ok;
    logic seq;
  } ep_route_t;

  typedef struct packed {
    logic td;
    logic ep;
    logic ta;
  } timer_start_t;

  // Limits in clock cycles
  localparam int TA_LIMIT_DEFAULT = 101;
  localparam int EP_LIMIT_DEFAULT = 23;
  localparam int TD_LIMIT_DEFAULT = 23;

endpackage

//--- source/usb_pkg.sv
package usb_pkg;

  // PID codes as they appear in the low nibble of the PID byte
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110,
    PID_PING  = 4'b0100
  } usb_pid_e;

  // DATAx view, bit 3 carries the sequence toggle
  typedef struct packed {
    logic       seq;
    logic [2:0] low;
  } pid_bits_t;

  typedef union packed {
    usb_pid_e  code;
    pid_bits_t bits;
  } usb_pid_u;

  typedef struct packed {
    usb_pid_u   pid;
    logic [6:0] addr;
    logic [3:0] endp;
  } token_t;

endpackage
